// ==== src/commit_pkg.sv ====
package commit_pkg;

    localparam int rob_idx_w = 4;           // slot bit + head pointer
    localparam int exc_w     = 5;

    // exception codes, nonzero means exception
    localparam logic [exc_w-1:0] exc_none      = 5'd0;
    localparam logic [exc_w-1:0] exc_interrupt = 5'd1;
    localparam logic [exc_w-1:0] exc_adel      = 5'd4;
    localparam logic [exc_w-1:0] exc_syscall   = 5'd8;
    localparam logic [exc_w-1:0] exc_overflow  = 5'd12;

    localparam logic [31:0] vec_boot_base   = 32'hbfc00200;
    localparam logic [31:0] vec_general_off = 32'h00000180;
    localparam logic [31:0] vec_intr_off    = 32'h00000200;

    // static part of a rob entry
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        is_alu;
        logic        is_mu;
        logic        is_mdu;
        logic        wen;
        logic        is_branch;
        logic        mustflush;
        logic        eret;
        logic [4:0]  waddr;
    } rob_entry_t;

    // one fu report, target is the bad vaddr for the mu
    typedef struct packed {
        logic             ready;
        logic [31:0]      result;
        logic [exc_w-1:0] excode;
        logic             taken;
        logic             mispredict;
        logic [31:0]      target;
    } fu_result_t;

    typedef struct packed {
        rob_entry_t entry;
        fu_result_t alu0;
        fu_result_t alu1;
        fu_result_t mu;
        fu_result_t mdu;
    } slot_in_t;

    typedef struct packed {
        logic             valid;
        logic             ready;
        logic [31:0]      pc;
        logic [31:0]      result;
        logic [exc_w-1:0] excode;
        logic             wen;
        logic [4:0]       waddr;
        logic             is_branch;
        logic             taken;
        logic             mispredict;
        logic [31:0]      target;
        logic             mustflush;
        logic             eret;
        logic             is_mem;
        logic [31:0]      bad_vaddr;
    } slot_eval_t;

    typedef struct packed {
        logic             can0;
        logic             can1;
        logic             en0;            // slot actually commits
        logic             en1;
        logic             flush0;
        logic             flush1;
        logic             intr;
        logic             exc_slot;       // 1 when slot1 takes the exception
        logic [exc_w-1:0] excode;
        logic             last_isbranch;
    } retire_t;

    typedef struct packed {
        logic        status_bev;
        logic        cause_iv;
        logic [17:0] ebase;
        logic [31:0] eretaddr;
    } cp0_state_t;

    typedef struct packed {
        logic        en;
        logic [31:0] pc;
        logic [31:0] target;
        logic        taken;
    } predictor_upd_t;

    typedef struct packed {
        logic [exc_w-1:0] excode;
        logic [31:0]      pc;
        logic             isslot;
        logic [31:0]      vaddr;
    } exception_rpt_t;

    typedef struct packed {
        logic                 en;
        logic [4:0]           waddr;
        logic [rob_idx_w-1:0] wnum;
        logic [31:0]          wdata;
    } arf_write_t;

endpackage

// ==== src/commit_slot_eval.sv ====
`timescale 1ns/100ps

module commit_slot_eval (
    input  commit_pkg::slot_in_t   slot,
    output commit_pkg::slot_eval_t eval
);

    logic                         alu_ready;
    commit_pkg::fu_result_t       alu_sel;      // whichever alu finished
    logic [commit_pkg::exc_w-1:0] excode;
    logic [31:0]                  result;

    assign alu_ready = slot.alu0.ready | slot.alu1.ready;
    assign alu_sel   = slot.alu0.ready ? slot.alu0 : slot.alu1;

    // result by unit type
    always_comb begin
        if (slot.entry.is_alu) begin
            result = alu_sel.result;
        end else if (slot.entry.is_mu) begin
            result = slot.mu.result;
        end else begin
            result = slot.mdu.result;
        end
    end

    // alu codes first, mu only when it flagged something
    always_comb begin
        if (alu_ready) begin
            excode = alu_sel.excode;
        end else if (slot.mu.ready && (slot.mu.excode != commit_pkg::exc_none)) begin
            excode = slot.mu.excode;
        end else begin
            excode = commit_pkg::exc_none;
        end
    end

    always_comb begin
        eval.valid      = slot.entry.valid;
        eval.ready      = alu_ready | slot.mu.ready | slot.mdu.ready;
        eval.pc         = slot.entry.pc;
        eval.result     = result;
        eval.excode     = excode;
        eval.wen        = slot.entry.wen;
        eval.waddr      = slot.entry.waddr;
        eval.mustflush  = slot.entry.mustflush;
        eval.eret       = slot.entry.eret;
        // branches resolve in the alus
        eval.is_branch  = slot.entry.is_branch;
        eval.taken      = alu_sel.taken;
        eval.mispredict = alu_sel.mispredict;
        eval.target     = alu_sel.target;
        eval.is_mem     = slot.entry.is_mu;
        eval.bad_vaddr  = slot.mu.target;   // mu reports bad vaddr here
    end

endmodule

// ==== src/commit_pairing.sv ====
`timescale 1ns/100ps

module commit_pairing (
    input  logic                   clk,
    input  logic                   resetn,
    input  commit_pkg::slot_eval_t eval0,
    input  commit_pkg::slot_eval_t eval1,
    input  logic [7:0]             ext_int,
    input  logic                   flush,
    input  logic                   rob_empty,
    output commit_pkg::retire_t    retire,
    output logic                   last_predfail,
    output logic [31:0]            last_target,
    output logic                   rob_pop,
    output logic                   rob_clear0,
    output logic                   rob_clear1
);

    logic last_isbranch;        // last retired instr was a branch
    logic can0;
    logic can1;
    logic go1;                  // slot1 really retires
    logic exc0;
    logic exc1;
    logic fail0;
    logic intr;
    logic flush0;
    logic flush1;

    assign exc0 = eval0.excode != commit_pkg::exc_none;
    assign exc1 = eval1.excode != commit_pkg::exc_none;

    // nothing leaves the head during the flush pulse
    assign can0 = ~flush & eval0.valid & eval0.ready;
    assign can1 = ~flush & eval1.valid & eval1.ready & (eval0.ready | ~eval0.valid);

    assign intr  = (|ext_int) & (can0 | can1);
    assign fail0 = can0 & eval0.is_branch & eval0.mispredict;   // slot1 is its delay slot

    // interrupt goes to slot0 when it can retire
    assign flush0 = can0 & (exc0 | eval0.mustflush | eval0.eret | last_predfail | intr);
    assign go1    = can1 & ~flush0;
    assign flush1 = go1 & (exc1 | eval1.mustflush | eval1.eret | fail0 | intr
                         | (last_predfail & ~eval0.valid));

    always_comb begin
        retire.can0          = can0;
        retire.can1          = can1;
        retire.en0           = can0 & ~exc0 & ~intr;
        retire.en1           = go1 & ~exc1 & ~intr;
        retire.flush0        = flush0;
        retire.flush1        = flush1;
        retire.intr          = intr;
        retire.exc_slot      = ~(can0 & (exc0 | intr));
        retire.last_isbranch = last_isbranch;
        if (intr) begin
            retire.excode = commit_pkg::exc_interrupt;
        end else if (can0 && exc0) begin
            retire.excode = eval0.excode;
        end else if (go1 && exc1) begin
            retire.excode = eval1.excode;
        end else begin
            retire.excode = commit_pkg::exc_none;
        end
    end

    // rob feedback
    assign rob_clear0 = can0;
    assign rob_clear1 = go1;
    assign rob_pop    = ~flush & ~rob_empty & ~(eval0.valid & ~can0) & ~(eval1.valid & ~go1);

    // tag follows the younger retiring instr
    always_ff @(posedge clk) begin
        if (!resetn) begin
            last_isbranch <= 1'b0;
            last_predfail <= 1'b0;
        end else if (flush) begin
            last_isbranch <= 1'b0;
            last_predfail <= 1'b0;
        end else if (go1) begin
            last_isbranch <= eval1.is_branch;
            last_predfail <= eval1.is_branch & eval1.mispredict;
            last_target   <= eval1.taken ? eval1.target : eval1.pc + 32'd8;
        end else if (can0) begin
            last_isbranch <= eval0.is_branch;
            last_predfail <= eval0.is_branch & eval0.mispredict;
            last_target   <= eval0.taken ? eval0.target : eval0.pc + 32'd8;
        end
    end

endmodule

// ==== src/redirect_target.sv ====
`timescale 1ns/100ps

module redirect_target (
    input  commit_pkg::slot_eval_t eval0,
    input  commit_pkg::slot_eval_t eval1,
    input  commit_pkg::retire_t    retire,
    input  logic                   last_predfail,
    input  logic [31:0]            last_target,
    input  commit_pkg::cp0_state_t cp0,
    output logic [31:0]            target
);

    logic [31:0] vec_base;
    logic [31:0] intr_off;
    logic [31:0] intr_target;
    logic [31:0] exc_target;
    logic        ret1;
    logic        eret_hit;
    logic        delay_last;        // head delay slot of an older mispredict
    logic        delay_pair;        // slot0 mispredicted, slot1 its delay slot

    assign vec_base = cp0.status_bev ? commit_pkg::vec_boot_base : {2'b10, cp0.ebase, 12'b0};
    assign intr_off = cp0.cause_iv ? commit_pkg::vec_intr_off : commit_pkg::vec_general_off;

    // top two bits stay fixed
    assign intr_target = {vec_base[31:30], vec_base[29:0] + intr_off[29:0]};
    assign exc_target  = {vec_base[31:30],
                          vec_base[29:0] + commit_pkg::vec_general_off[29:0]};

    assign ret1       = retire.can1 & ~retire.flush0;
    assign eret_hit   = (retire.en0 & eval0.eret) | (retire.en1 & eval1.eret);
    assign delay_last = last_predfail & (retire.can0 | (ret1 & ~eval0.valid));
    assign delay_pair = retire.can0 & ret1 & eval0.is_branch & eval0.mispredict;

    always_comb begin
        if (retire.intr) begin
            target = intr_target;
        end else if (retire.excode != commit_pkg::exc_none) begin
            target = exc_target;
        end else if (eret_hit) begin
            target = cp0.eretaddr;
        end else if (delay_last) begin
            target = last_target;
        end else if (delay_pair) begin
            target = eval0.taken ? eval0.target : eval0.pc + 32'd8;
        end else if (retire.can0 && eval0.mustflush) begin
            target = eval0.pc + 32'd4;
        end else begin
            target = eval1.pc + 32'd4;      // slot1 mustflush
        end
    end

endmodule

// ==== src/commit_output_regs.sv ====
`timescale 1ns/100ps

module commit_output_regs (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  commit_pkg::slot_eval_t                eval0,
    input  commit_pkg::slot_eval_t                eval1,
    input  commit_pkg::retire_t                   retire,
    input  logic [31:0]                           target,
    input  logic [commit_pkg::rob_idx_w-2:0]      rob_head,
    output logic                                  commit_en0,
    output logic                                  commit_en1,
    output logic [commit_pkg::rob_idx_w-1:0]      commit_num0,
    output logic [commit_pkg::rob_idx_w-1:0]      commit_num1,
    output commit_pkg::arf_write_t                arf0,
    output commit_pkg::arf_write_t                arf1,
    output commit_pkg::predictor_upd_t            predictor,
    output commit_pkg::exception_rpt_t            exception,
    output logic                                  flush,
    output logic [31:0]                           flush_target
);

    logic [commit_pkg::rob_idx_w-1:0] num0;
    logic [commit_pkg::rob_idx_w-1:0] num1;
    logic                             br0;      // slot0 is a committing branch
    logic                             br1;
    commit_pkg::slot_eval_t           exc_src;  // slot that takes the exception

    assign num0    = {1'b0, rob_head};
    assign num1    = {1'b1, rob_head};
    assign br0     = retire.en0 & eval0.is_branch;
    assign br1     = retire.en1 & eval1.is_branch;
    assign exc_src = retire.exc_slot ? eval1 : eval0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            commit_en0       <= 1'b0;
            commit_en1       <= 1'b0;
            arf0.en          <= 1'b0;
            arf1.en          <= 1'b0;
            predictor.en     <= 1'b0;
            exception.excode <= commit_pkg::exc_none;
            flush            <= 1'b0;
        end else if (flush) begin
            commit_en0       <= 1'b0;
            commit_en1       <= 1'b0;
            arf0.en          <= 1'b0;
            arf1.en          <= 1'b0;
            predictor.en     <= 1'b0;
            exception.excode <= commit_pkg::exc_none;
            flush            <= 1'b0;       // single pulse
        end else begin
            commit_en0  <= retire.en0;
            commit_en1  <= retire.en1;
            commit_num0 <= num0;
            commit_num1 <= num1;

            arf0.en    <= retire.en0 & eval0.wen;
            arf0.waddr <= eval0.waddr;
            arf0.wnum  <= num0;
            arf0.wdata <= eval0.result;
            arf1.en    <= retire.en1 & eval1.wen;
            arf1.waddr <= eval1.waddr;
            arf1.wnum  <= num1;
            arf1.wdata <= eval1.result;

            // older branch wins
            predictor.en     <= br0 | br1;
            predictor.pc     <= br0 ? eval0.pc : eval1.pc;
            predictor.target <= br0 ? eval0.target : eval1.target;
            predictor.taken  <= br0 ? eval0.taken : eval1.taken;

            exception.excode <= retire.excode;
            exception.pc     <= exc_src.pc;
            exception.vaddr  <= exc_src.is_mem ? exc_src.bad_vaddr : exc_src.pc;
            if (!retire.exc_slot || !eval0.valid) begin
                exception.isslot <= retire.last_isbranch;
            end else begin
                exception.isslot <= eval0.is_branch;   // slot1 behind a slot0 branch
            end

            flush        <= retire.flush0 | retire.flush1 | retire.intr;
            flush_target <= target;
        end
    end

endmodule

// ==== src/commit_stage.sv ====
`timescale 1ns/100ps

module commit_stage (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  commit_pkg::slot_in_t                  slot0,
    input  commit_pkg::slot_in_t                  slot1,
    input  logic [commit_pkg::rob_idx_w-2:0]      rob_head,
    input  logic                                  rob_empty,
    input  commit_pkg::cp0_state_t                cp0,
    input  logic [7:0]                            ext_int,
    output logic                                  rob_pop,
    output logic                                  rob_clear0,
    output logic                                  rob_clear1,
    output logic                                  commit_en0,
    output logic                                  commit_en1,
    output logic [commit_pkg::rob_idx_w-1:0]      commit_num0,
    output logic [commit_pkg::rob_idx_w-1:0]      commit_num1,
    output commit_pkg::arf_write_t                arf0,
    output commit_pkg::arf_write_t                arf1,
    output commit_pkg::predictor_upd_t            predictor,
    output commit_pkg::exception_rpt_t            exception,
    output logic                                  flush,
    output logic [31:0]                           flush_target
);

    commit_pkg::slot_eval_t eval0;
    commit_pkg::slot_eval_t eval1;
    commit_pkg::retire_t    retire;
    logic                   last_predfail;
    logic [31:0]            last_target;
    logic [31:0]            target;     // redirect, registered into flush_target

    commit_slot_eval u_slot_eval0 (
        .slot (slot0),
        .eval (eval0)
    );

    commit_slot_eval u_slot_eval1 (
        .slot (slot1),
        .eval (eval1)
    );

    commit_pairing u_pairing (
        .clk           (clk),
        .resetn        (resetn),
        .eval0         (eval0),
        .eval1         (eval1),
        .ext_int       (ext_int),
        .flush         (flush),
        .rob_empty     (rob_empty),
        .retire        (retire),
        .last_predfail (last_predfail),
        .last_target   (last_target),
        .rob_pop       (rob_pop),
        .rob_clear0    (rob_clear0),
        .rob_clear1    (rob_clear1)
    );

    redirect_target u_redirect (
        .eval0         (eval0),
        .eval1         (eval1),
        .retire        (retire),
        .last_predfail (last_predfail),
        .last_target   (last_target),
        .cp0           (cp0),
        .target        (target)
    );

    commit_output_regs u_output_regs (
        .clk          (clk),
        .resetn       (resetn),
        .eval0        (eval0),
        .eval1        (eval1),
        .retire       (retire),
        .target       (target),
        .rob_head     (rob_head),
        .commit_en0   (commit_en0),
        .commit_en1   (commit_en1),
        .commit_num0  (commit_num0),
        .commit_num1  (commit_num1),
        .arf0         (arf0),
        .arf1         (arf1),
        .predictor    (predictor),
        .exception    (exception),
        .flush        (flush),
        .flush_target (flush_target)
    );

endmodule

// ==== tb/commit_stage_tb.sv ====
`timescale 1ns/100ps

module commit_stage_tb;

    localparam int n_tests   = 6;
    localparam int rec_words = 19;      // trace words per test

    logic                                 clk;
    logic                                 resetn;
    commit_pkg::slot_in_t                 slot0;
    commit_pkg::slot_in_t                 slot1;
    logic [commit_pkg::rob_idx_w-2:0]     rob_head;
    logic                                 rob_empty;
    commit_pkg::cp0_state_t               cp0;
    logic [7:0]                           ext_int;
    logic                                 rob_pop;
    logic                                 rob_clear0;
    logic                                 rob_clear1;
    logic                                 commit_en0;
    logic                                 commit_en1;
    logic [commit_pkg::rob_idx_w-1:0]     commit_num0;
    logic [commit_pkg::rob_idx_w-1:0]     commit_num1;
    commit_pkg::arf_write_t               arf0;
    commit_pkg::arf_write_t               arf1;
    commit_pkg::predictor_upd_t           predictor;
    commit_pkg::exception_rpt_t           exception;
    logic                                 flush;
    logic [31:0]                          flush_target;

    logic [31:0] trace [0:n_tests*rec_words-1];
    int          errors;
    int          passed;
    int          failed;
    int          i;
    bit          timed_out;

    // what the registered outputs showed during one test
    bit                               en0_seen;
    bit                               en1_seen;
    bit                               pred_seen;
    int                               flush_cycles;
    logic [commit_pkg::rob_idx_w-1:0] num0_got;
    logic [commit_pkg::rob_idx_w-1:0] num1_got;
    commit_pkg::arf_write_t           arf0_got;
    commit_pkg::arf_write_t           arf1_got;
    commit_pkg::predictor_upd_t       pred_got;
    commit_pkg::exception_rpt_t       exc_got;
    logic [31:0]                      target_got;

    commit_stage u_commit_stage (
        .clk          (clk),
        .resetn       (resetn),
        .slot0        (slot0),
        .slot1        (slot1),
        .rob_head     (rob_head),
        .rob_empty    (rob_empty),
        .cp0          (cp0),
        .ext_int      (ext_int),
        .rob_pop      (rob_pop),
        .rob_clear0   (rob_clear0),
        .rob_clear1   (rob_clear1),
        .commit_en0   (commit_en0),
        .commit_en1   (commit_en1),
        .commit_num0  (commit_num0),
        .commit_num1  (commit_num1),
        .arf0         (arf0),
        .arf1         (arf1),
        .predictor    (predictor),
        .exception    (exception),
        .flush        (flush),
        .flush_target (flush_target)
    );

    always #10 clk = ~clk;

    // ctrl nibbles from the top are valid, unit, ready, wen, {eret,mustflush,branch},
    // {mispredict,taken} and waddr
    function automatic commit_pkg::slot_in_t build_slot(input logic [31:0] ctrl,
            input logic [31:0] pc, input logic [31:0] result,
            input logic [31:0] excode, input logic [31:0] target);
        commit_pkg::slot_in_t   s;
        commit_pkg::fu_result_t fu;
        s                 = '0;
        fu.ready          = 1'b1;
        fu.result         = result;
        fu.excode         = excode[commit_pkg::exc_w-1:0];
        fu.taken          = ctrl[8];
        fu.mispredict     = ctrl[9];
        fu.target         = target;     // bad vaddr for the mu
        s.entry.valid     = ctrl[28];
        s.entry.pc        = pc;
        s.entry.is_alu    = ctrl[27:24] < 4'd2;
        s.entry.is_mu     = ctrl[27:24] == 4'd2;
        s.entry.is_mdu    = ctrl[27:24] == 4'd3;
        s.entry.wen       = ctrl[16];
        s.entry.is_branch = ctrl[12];
        s.entry.mustflush = ctrl[13];
        s.entry.eret      = ctrl[14];
        s.entry.waddr     = ctrl[4:0];
        if (ctrl[28]) begin
            case (ctrl[27:24])
                4'd0: s.alu0 = fu;
                4'd1: s.alu1 = fu;
                4'd2: s.mu = fu;
                default: s.mdu = fu;
            endcase
        end
        return s;
    endfunction

    // entry still waiting on its unit
    function automatic commit_pkg::slot_in_t hold_ready(input commit_pkg::slot_in_t s);
        commit_pkg::slot_in_t h;
        h            = s;
        h.alu0.ready = 1'b0;
        h.alu1.ready = 1'b0;
        h.mu.ready   = 1'b0;
        h.mdu.ready  = 1'b0;
        return h;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_num(input string name, input logic [commit_pkg::rob_idx_w-1:0] got,
            input logic [commit_pkg::rob_idx_w-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_arf(input string name, input commit_pkg::arf_write_t got,
            input commit_pkg::arf_write_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_predictor(input string name, input commit_pkg::predictor_upd_t got,
            input commit_pkg::predictor_upd_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_exception(input string name, input commit_pkg::exception_rpt_t got,
            input commit_pkg::exception_rpt_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_target(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic capture_outputs();
        if (commit_en0) begin
            en0_seen = 1'b1;
            num0_got = commit_num0;
            arf0_got = arf0;
        end
        if (commit_en1) begin
            en1_seen = 1'b1;
            num1_got = commit_num1;
            arf1_got = arf1;
        end
        if (predictor.en) begin
            pred_seen = 1'b1;
            pred_got  = predictor;
        end
        if (flush) begin
            flush_cycles++;
            exc_got    = exception;     // report is valid alongside flush
            target_got = flush_target;
        end
    endtask

    task automatic run_test(input int t);
        int                         base;
        int                         cycles;
        int                         start_errors;
        bit                         done;
        bit                         clr0;
        bit                         clr1;
        logic [31:0]                flags;
        commit_pkg::slot_in_t       s0;
        commit_pkg::slot_in_t       s1;
        commit_pkg::arf_write_t     arf_exp;
        commit_pkg::predictor_upd_t pred_exp;
        commit_pkg::exception_rpt_t exc_exp;
        base         = t * rec_words;
        start_errors = errors;
        s0    = build_slot(trace[base], trace[base+1], trace[base+2], trace[base+3], trace[base+4]);
        s1    = build_slot(trace[base+5], trace[base+6], trace[base+7], trace[base+8],
                           trace[base+9]);
        flags = trace[base+13];
        en0_seen     = 1'b0;
        en1_seen     = 1'b0;
        pred_seen    = 1'b0;
        flush_cycles = 0;

        @(posedge clk);
        #2;
        slot0          = trace[base][20] ? s0 : hold_ready(s0);
        slot1          = trace[base+5][20] ? s1 : hold_ready(s1);
        cp0.status_bev = trace[base+10][28];
        cp0.cause_iv   = trace[base+10][24];
        cp0.ebase      = trace[base+11][17:0];
        cp0.eretaddr   = trace[base+12];
        ext_int        = trace[base+10][7:0];
        rob_head       = t[2:0];
        rob_empty      = 1'b0;
        #1;
        check_flag("rob_pop", rob_pop, flags[8]);
        check_flag("rob_clear0", rob_clear0, flags[4]);
        check_flag("rob_clear1", rob_clear1, flags[0]);

        // cleared entries leave the rob and waiting units report one cycle later
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 50) begin
            done = rob_pop | flush;
            clr0 = rob_clear0;
            clr1 = rob_clear1;
            capture_outputs();
            @(posedge clk);
            #2;
            if (done) begin
                slot0     = '0;
                slot1     = '0;
                ext_int   = 8'h00;
                rob_empty = 1'b1;
            end else begin
                slot0 = clr0 ? '0 : s0;
                slot1 = clr1 ? '0 : s1;
            end
            #1;
            cycles++;
        end
        if (!done) begin
            $display("timeout waiting for rob_pop or flush in test %0d", t + 1);
            timed_out = 1'b1;
            errors++;
        end else begin
            capture_outputs();
            check_flag("commit_en0", en0_seen, flags[28]);
            check_flag("commit_en1", en1_seen, flags[24]);
            check_flag("flush", flush_cycles != 0, flags[20]);
            check_flag("predictor.en", pred_seen, flags[16]);
            if (flush_cycles > 1) begin
                $display("flush stayed high for %0d cycles instead of one", flush_cycles);
                errors++;
            end
            if (flags[28]) begin
                check_num("commit_num0", num0_got, {1'b0, t[2:0]});
                arf_exp = {s0.entry.wen, s0.entry.waddr, {1'b0, t[2:0]}, trace[base+2]};
                check_arf("arf0", arf0_got, arf_exp);
            end
            if (flags[24]) begin
                check_num("commit_num1", num1_got, {1'b1, t[2:0]});
                arf_exp = {s1.entry.wen, s1.entry.waddr, {1'b1, t[2:0]}, trace[base+7]};
                check_arf("arf1", arf1_got, arf_exp);
            end
            if (flags[16]) begin
                pred_exp = {1'b1, trace[base+17], trace[base+18], flags[12]};
                check_predictor("predictor", pred_got, pred_exp);
            end
            if (flags[20]) begin
                check_target("flush_target", target_got, trace[base+16]);
            end
            if (trace[base+14] != 32'd0) begin
                // no branch ahead and vaddr is the pc for non-memory faults
                exc_exp = {trace[base+14][commit_pkg::exc_w-1:0], trace[base+15], 1'b0,
                           trace[base+15]};
                check_exception("exception", exc_got, exc_exp);
            end
        end
        if (errors == start_errors) begin
            passed++;
            $display("test %0d ok", t + 1);
        end else begin
            failed++;
            $display("test %0d failed", t + 1);
        end
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        slot0     = '0;
        slot1     = '0;
        rob_head  = '0;
        rob_empty = 1'b1;
        cp0       = '0;
        ext_int   = 8'h00;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        $readmemh("tb/commit_trace.txt", trace);

        for (i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        #2;
        resetn = 1'b1;
        #1;
        check_flag("commit_en0", commit_en0, 1'b0);
        check_flag("commit_en1", commit_en1, 1'b0);
        check_flag("arf0.en", arf0.en, 1'b0);
        check_flag("arf1.en", arf1.en, 1'b0);
        check_flag("flush", flush, 1'b0);
        check_flag("predictor.en", predictor.en, 1'b0);

        for (i = 0; i < n_tests && !timed_out; i++) begin
            run_test(i);
        end

        $display("tests passed %0d failed %0d", passed, failed);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb/commit_trace.txt ====
// slot lines: ctrl pc result excode target, ctrl nibbles valid unit ready wen flags outcome waddr
// cp0 line: {bev, iv, ext_int} ebase eretaddr
// expected: {en0 en1 flush pred_en pred_taken pop clear0 clear1} excode exc_pc target pred_pc pred_target
10110005 bfc00000 11111111 00000000 00000000
11110006 bfc00004 22222222 00000000 00000000
00000000 00000000 00000000
11000111 00000000 00000000 00000000 00000000 00000000
10110007 bfc00010 33333333 00000000 00000000
13010008 bfc00014 44444444 00000000 00000000
00000000 00000000 00000000
11000010 00000000 00000000 00000000 00000000 00000000
10110009 bfc00020 55555555 0000000c 00000000
1111000a bfc00024 66666666 00000000 00000000
10000000 00000000 00000000
00100010 0000000c bfc00020 bfc00380 00000000 00000000
10101300 bfc00030 00000000 00000000 bfc01000
1111000b bfc00034 77777777 00000000 00000000
00000000 00000000 00000000
11111111 00000000 00000000 bfc01000 bfc00030 bfc01000
10104000 bfc00040 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000000 00000000 80002000
10100110 00000000 00000000 80002000 00000000 00000000
1011000c bfc00050 88888888 00000000 00000000
1111000d bfc00054 99999999 00000000 00000000
01000001 00000401 00000000
00100010 00000001 bfc00050 80401200 00000000 00000000

// ==== list.f ====
src/commit_pkg.sv
src/commit_slot_eval.sv
src/commit_pairing.sv
src/redirect_target.sv
src/commit_output_regs.sv
src/commit_stage.sv
tb/commit_stage_tb.sv

// ==== Makefile ====
TOP = commit_stage_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
